// ==== Bender.yml ====
package:
  name: rv32i_pipe

sources:
  - hw/core_pkg.sv
  - hw/pipe_pkg.sv
  - hw/fetch_queue.sv
  - hw/id_stage.sv
  - hw/ex_stage.sv
  - hw/ls_stage.sv
  - hw/core_top.sv
  - target: test
    files:
      - dv/core_props.sv
      - dv/core_tb.sv

// ==== dv/core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_props
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              push_i,
    input  wire logic [FQ_PTR_W:0] count_i,
    input  retire_t                retire_i
);

    int unsigned fail_count = 0;

    a_occupancy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) count_i <= FQ_DEPTH
    ) else begin
        fail_count++;
        $error("fetch queue holds more entries than its depth");
    end

    // producer must hold back once its credits are spent
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(push_i && count_i == FQ_DEPTH)
    ) else begin
        fail_count++;
        $error("push into a full fetch queue");
    end

    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(retire_i.valid && retire_i.we && retire_i.rd == '0)
    ) else begin
        fail_count++;
        $error("retire writes x0");
    end

endmodule

bind core_top core_props u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .push_i   (instr_valid_i),
    .count_i  (u_fetch_queue.count_q),
    .retire_i (retire_o)
);

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb
    import core_pkg::*;
    import pipe_pkg::*;
();

    localparam int SEED        = 21429;
    localparam int N_INSTR     = 2000;
    localparam int N_DIRECTED  = 14;
    localparam int PUSH_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 100;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_LUI, K_LW, K_SW
    } kind_e;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic            credit;
    retire_t         retire;

    // instruction-set model
    logic [XLEN-1:0] m_rf  [8];
    logic [XLEN-1:0] m_mem [DMEM_WORDS];
    logic [XLEN-1:0] m_pc;
    retire_t         exp_q [$];

    int credits;
    int n_pushed;
    int gap;
    bit can_push;

    core_top uut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .credit_o      (credit),
        .retire_o      (retire)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(
        input string           name,
        input logic [XLEN-1:0] exp,
        input logic [XLEN-1:0] act
    );
        abort_run($sformatf("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, exp, act);
        end
    endtask

    task automatic check_credits(input int exp, input int act);
        if (act != exp) begin
            report_mismatch("credits", exp, act);
        end
    endtask

    // rd and data only mean something when the instruction writes
    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act.pc !== exp.pc) begin
            report_mismatch("retire_o.pc", exp.pc, act.pc);
        end
        if (act.we !== exp.we) begin
            report_mismatch("retire_o.we", exp.we, act.we);
        end
        if (exp.we && act.rd !== exp.rd) begin
            report_mismatch("retire_o.rd", exp.rd, act.rd);
        end
        if (exp.we && act.data !== exp.data) begin
            report_mismatch("retire_o.data", exp.data, act.data);
        end
    endtask

    function automatic logic [31:0] encode_instr(
        input kind_e           k,
        input logic [4:0]      rd,
        input logic [4:0]      rs1,
        input logic [4:0]      rs2,
        input logic [XLEN-1:0] imm
    );
        logic [31:0] w;
        case (k)
            K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:   w = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_SLL:   w = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
            K_SRL:   w = {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
            K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LUI:   w = {imm[31:12], rd, 7'b0110111};
            K_LW:    w = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            default: w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        endcase
        return w;
    endfunction

    // step the model, queue its retire and drive the word
    task automatic push_instr(
        input kind_e           k,
        input logic [4:0]      rd,
        input logic [4:0]      rs1,
        input logic [4:0]      rs2,
        input logic [XLEN-1:0] imm
    );
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        retire_t         exp;
        a         = m_rf[rs1];
        b         = m_rf[rs2];
        addr      = a + imm;
        exp       = '0;
        exp.valid = 1'b1;
        exp.pc    = m_pc;
        exp.rd    = rd;
        exp.we    = (k != K_SW) && (rd != 5'd0);
        case (k)
            K_ADD:   exp.data = a + b;
            K_SUB:   exp.data = a - b;
            K_AND:   exp.data = a & b;
            K_OR:    exp.data = a | b;
            K_XOR:   exp.data = a ^ b;
            K_SLT:   exp.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLL:   exp.data = a << b[4:0];
            K_SRL:   exp.data = a >> b[4:0];
            K_ADDI:  exp.data = a + imm;
            K_LUI:   exp.data = imm;
            K_LW:    exp.data = m_mem[addr[5:2]];
            default: m_mem[addr[5:2]] = b;
        endcase
        if (exp.we) begin
            m_rf[rd] = exp.data;
        end
        m_pc = m_pc + 32'd4;
        exp_q.push_back(exp);
        instr_valid <= 1'b1;
        instr       <= encode_instr(k, rd, rs1, rs2, imm);
        credits  = credits - 1;
        n_pushed = n_pushed + 1;
    endtask

    task automatic push_random();
        int              pick;
        kind_e           k;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] raw;
        logic [XLEN-1:0] imm;
        pick = $urandom_range(0, 99);
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        raw  = $urandom();
        imm  = {{20{raw[11]}}, raw[11:0]};
        if (pick < 40) begin
            k = kind_e'($urandom_range(0, 7));
        end else if (pick < 62) begin
            k = K_ADDI;
            // feed shift edge amounts into later shifts
            case ($urandom_range(0, 3))
                0:       imm = 32'd0;
                1:       imm = 32'd31;
                default: imm = imm;
            endcase
        end else if (pick < 70) begin
            k   = K_LUI;
            imm = {raw[31:12], 12'b0};
        end else begin
            k   = (pick < 85) ? K_LW : K_SW;
            rs1 = 5'd0;
            imm = 32'($urandom_range(0, DMEM_WORDS - 1)) << 2;
        end
        push_instr(k, rd, rs1, rs2, imm);
    endtask

    // corner cases first, pushed back to back
    task automatic push_directed(input int idx);
        case (idx)
            0:       push_instr(K_LUI, 5'd1, 5'd0, 5'd0, 32'h8000_0000);
            1:       push_instr(K_ADDI, 5'd2, 5'd0, 5'd0, 32'hFFFF_FFFB);
            2:       push_instr(K_SLT, 5'd3, 5'd1, 5'd2, 32'd0);
            3:       push_instr(K_SLT, 5'd4, 5'd2, 5'd1, 32'd0);
            4:       push_instr(K_ADDI, 5'd5, 5'd0, 5'd0, 32'd31);
            5:       push_instr(K_SLL, 5'd6, 5'd2, 5'd0, 32'd0);
            6:       push_instr(K_SRL, 5'd7, 5'd2, 5'd5, 32'd0);
            7:       push_instr(K_SLL, 5'd6, 5'd2, 5'd5, 32'd0);
            8:       push_instr(K_SW, 5'd0, 5'd0, 5'd2, 32'd8);
            9:       push_instr(K_LW, 5'd3, 5'd0, 5'd0, 32'd8);
            10:      push_instr(K_ADD, 5'd4, 5'd3, 5'd3, 32'd0);
            11:      push_instr(K_LW, 5'd5, 5'd0, 5'd0, 32'd60);
            12:      push_instr(K_ADDI, 5'd0, 5'd2, 5'd0, 32'd7);
            13:      push_instr(K_OR, 5'd6, 5'd0, 5'd0, 32'd0);
            default: push_random();
        endcase
    endtask

    // push decision uses the credits held before this edge
    task automatic clock_edge();
        @(posedge clk);
        can_push = (credits > 0);
        instr_valid <= 1'b0;
        if (credit) begin
            credits = credits + 1;
        end
        if (credits > FQ_DEPTH) begin
            abort_run("credit returned without a matching push");
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("retire seen with no instruction outstanding");
            end else begin
                check_retire(exp_q.pop_front(), retire);
            end
        end
    end

    initial begin
        int cyc;
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        credits     = FQ_DEPTH;
        n_pushed    = 0;
        gap         = 0;
        can_push    = 1'b0;
        m_pc        = '0;
        for (int i = 0; i < 8; i++) begin
            m_rf[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            m_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // nothing pushed yet
        for (int i = 0; i < 4; i++) begin
            clock_edge();
            compare_flag("credit_o", 1'b0, credit);
            compare_flag("retire_o.valid", 1'b0, retire.valid);
        end

        for (cyc = 0; cyc < PUSH_LIMIT && n_pushed < N_INSTR; cyc++) begin
            clock_edge();
            if (gap > 0) begin
                gap = gap - 1;
            end else if (can_push) begin
                if (n_pushed < N_DIRECTED) begin
                    push_directed(n_pushed);
                end else if ($urandom_range(0, 3) == 0) begin
                    // idle, now and then a longer pause
                    gap = ($urandom_range(0, 7) == 0) ? $urandom_range(2, 9) : 0;
                end else begin
                    push_random();
                end
            end
        end
        if (n_pushed < N_INSTR) begin
            abort_run("timed out before every instruction was pushed");
        end

        for (cyc = 0; cyc < DRAIN_LIMIT && exp_q.size() != 0; cyc++) begin
            clock_edge();
        end
        if (exp_q.size() != 0) begin
            abort_run("timed out waiting for the pipeline to retire every instruction");
        end
        check_credits(FQ_DEPTH, credits);

        if (uut.u_props.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("concurrent assertions in core_props failed");
        end
    end

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // data path and pc width
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;

    // data memory, word addressed by addr[5:2]
    localparam int DMEM_WORDS = 16;
    localparam int DMEM_IDX_W = 4;

    // funct7 values of the OP group
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // funct3 values
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            instr_valid_i,
    input  wire logic [XLEN-1:0] instr_i,
    output logic                 credit_o,
    output retire_t              retire_o
);

    logic    fetch_valid;
    fetch_t  fetch;
    id_ex_t  id_ex;
    ex_ls_t  ex_ls;
    retire_t ls_fwd;

    fetch_queue u_fetch_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .credit_o      (credit_o),
        .fetch_valid_o (fetch_valid),
        .fetch_o       (fetch)
    );

    // the retire bus doubles as the register file write port
    id_stage u_id_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid),
        .fetch_i       (fetch),
        .wb_i          (retire_o),
        .id_ex_o       (id_ex)
    );

    ex_stage u_ex_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ls_fwd_i (ls_fwd),
        .wb_i     (retire_o),
        .ex_ls_o  (ex_ls)
    );

    ls_stage u_ls_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ex_ls_i  (ex_ls),
        .ls_fwd_o (ls_fwd),
        .retire_o (retire_o)
    );

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  id_ex_t    id_ex_i,
    input  retire_t   ls_fwd_i,
    input  retire_t   wb_i,
    output ex_ls_t    ex_ls_o
);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    rs2_fwd;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               slt;
    logic [XLEN-1:0]    alu_res;
    ex_ls_t             ex_ls_d;
    ex_ls_t             ex_ls_q;

    // the younger producer in load/store has priority over writeback
    function automatic logic [XLEN-1:0] fwd_sel(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      reg_val
    );
        logic [XLEN-1:0] val;
        if (idx != '0 && ls_fwd_i.valid && ls_fwd_i.we && ls_fwd_i.rd == idx) begin
            val = ls_fwd_i.data;
        end else if (idx != '0 && wb_i.valid && wb_i.we && wb_i.rd == idx) begin
            val = wb_i.data;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    assign op_a    = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_val);
    assign rs2_fwd = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_val);
    assign op_b    = id_ex_i.src_imm ? id_ex_i.imm : rs2_fwd;
    assign shamt   = op_b[SHAMT_W-1:0];
    assign slt     = ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, slt};
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // loads and stores use the sum as their address
    always_comb begin
        ex_ls_d            = '0;
        ex_ls_d.valid      = id_ex_i.valid;
        ex_ls_d.pc         = id_ex_i.pc;
        ex_ls_d.alu_res    = alu_res;
        ex_ls_d.store_data = rs2_fwd;
        ex_ls_d.load       = id_ex_i.load;
        ex_ls_d.store      = id_ex_i.store;
        ex_ls_d.we         = id_ex_i.we;
        ex_ls_d.rd         = id_ex_i.rd;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_ls_q.valid <= 1'b0;
            ex_ls_q.load  <= 1'b0;
            ex_ls_q.store <= 1'b0;
            ex_ls_q.we    <= 1'b0;
        end else begin
            ex_ls_q <= ex_ls_d;
        end
    end

    assign ex_ls_o = ex_ls_q;

endmodule

`default_nettype wire

// ==== hw/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            instr_valid_i,
    input  wire logic [XLEN-1:0] instr_i,
    output logic                 credit_o,
    output logic                 fetch_valid_o,
    output fetch_t               fetch_o
);

    logic [XLEN-1:0]     mem [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] wr_ptr_q;
    logic [FQ_PTR_W-1:0] rd_ptr_q;
    logic [FQ_PTR_W:0]   count_q;
    logic [XLEN-1:0]     pc_q;
    logic                push;
    logic                pop;

    // downstream never stalls, so any held entry leaves right away
    assign pop  = (count_q != '0);
    assign push = instr_valid_i;

    assign credit_o      = pop;
    assign fetch_valid_o = pop;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pc_q     <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                // no branches, so pc only steps by one word
                pc_q     <= pc_q + 32'd4;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic fetch_valid_i,
    input  fetch_t    fetch_i,
    input  retire_t   wb_i,
    output id_ex_t    id_ex_o
);

    logic                 if_valid_q;
    fetch_t               if_q;
    logic [XLEN-1:0]      rf [1:2**REG_IDX_W-1];
    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 supported;
    logic                 writes_rd;
    id_ex_t               id_ex_d;
    id_ex_t               id_ex_q;

    // x0 is hardwired, a matching writeback wins over the array
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_IDX_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_i.valid && wb_i.we && wb_i.rd == idx) begin
            val = wb_i.data;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_valid_q <= 1'b0;
        end else begin
            if_valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            if_q <= fetch_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_i.valid && wb_i.we && wb_i.rd != '0) begin
            rf[wb_i.rd] <= wb_i.data;
        end
    end

    assign opcode = opcode_e'(if_q.instr[6:0]);
    assign funct3 = if_q.instr[14:12];
    assign funct7 = if_q.instr[31:25];

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_valid_q;
        id_ex_d.pc      = if_q.pc;
        id_ex_d.rs1     = if_q.instr[19:15];
        id_ex_d.rs2     = if_q.instr[24:20];
        id_ex_d.rd      = if_q.instr[11:7];
        id_ex_d.rs1_val = rf_read(if_q.instr[19:15]);
        id_ex_d.rs2_val = rf_read(if_q.instr[24:20]);
        id_ex_d.alu_op  = ALU_ADD;
        supported       = 1'b0;
        writes_rd       = 1'b0;

        case (opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                supported = 1'b1;
                if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    id_ex_d.alu_op = ALU_SUB;
                end else if (funct7 != F7_BASE) begin
                    supported = 1'b0;
                end else begin
                    case (funct3)
                        F3_ADD:  id_ex_d.alu_op = ALU_ADD;
                        F3_AND:  id_ex_d.alu_op = ALU_AND;
                        F3_OR:   id_ex_d.alu_op = ALU_OR;
                        F3_XOR:  id_ex_d.alu_op = ALU_XOR;
                        F3_SLT:  id_ex_d.alu_op = ALU_SLT;
                        F3_SLL:  id_ex_d.alu_op = ALU_SLL;
                        F3_SRL:  id_ex_d.alu_op = ALU_SRL;
                        default: supported = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // only ADDI of the immediate group
                supported       = (funct3 == F3_ADD);
                writes_rd       = 1'b1;
                id_ex_d.src_imm = 1'b1;
                id_ex_d.imm     = {{20{if_q.instr[31]}}, if_q.instr[31:20]};
            end
            OPC_LUI: begin
                supported       = 1'b1;
                writes_rd       = 1'b1;
                id_ex_d.src_imm = 1'b1;
                id_ex_d.alu_op  = ALU_PASS_B;
                id_ex_d.imm     = {if_q.instr[31:12], 12'b0};
            end
            OPC_LOAD: begin
                supported       = (funct3 == F3_WORD);
                writes_rd       = 1'b1;
                id_ex_d.load    = supported;
                id_ex_d.src_imm = 1'b1;
                id_ex_d.imm     = {{20{if_q.instr[31]}}, if_q.instr[31:20]};
            end
            OPC_STORE: begin
                supported       = (funct3 == F3_WORD);
                id_ex_d.store   = supported;
                id_ex_d.src_imm = 1'b1;
                id_ex_d.imm     = {{20{if_q.instr[31]}}, if_q.instr[31:25], if_q.instr[11:7]};
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // unsupported or x0 destination retires without a write
        id_ex_d.we = supported && writes_rd && (if_q.instr[11:7] != '0);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.load  <= 1'b0;
            id_ex_q.store <= 1'b0;
            id_ex_q.we    <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== hw/ls_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_stage
    import core_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  ex_ls_t    ex_ls_i,
    output retire_t   ls_fwd_o,
    output retire_t   retire_o
);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;
    logic [XLEN-1:0]       load_data;
    retire_t               wb_q;

    // word index, byte offset ignored
    assign word_idx  = ex_ls_i.alu_res[DMEM_IDX_W+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_ls_i.valid && ex_ls_i.store) begin
            dmem[word_idx] <= ex_ls_i.store_data;
        end
    end

    // stage result, also the forwarding source for execute
    always_comb begin
        ls_fwd_o.valid = ex_ls_i.valid;
        ls_fwd_o.pc    = ex_ls_i.pc;
        ls_fwd_o.rd    = ex_ls_i.rd;
        ls_fwd_o.we    = ex_ls_i.we;
        ls_fwd_o.data  = ex_ls_i.load ? load_data : ex_ls_i.alu_res;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
            wb_q.we    <= 1'b0;
        end else begin
            wb_q <= ls_fwd_o;
        end
    end

    assign retire_o = wb_q;

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;
    import core_pkg::*;

    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = 2;

    // queue output, pc stamped on dequeue
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_t;

    // decode to execute
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;
        alu_op_e              alu_op;
        logic                 src_imm;
        logic                 load;
        logic                 store;
        logic                 we;
        logic [REG_IDX_W-1:0] rd;
    } id_ex_t;

    // execute to load/store
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      alu_res;
        logic [XLEN-1:0]      store_data;
        logic                 load;
        logic                 store;
        logic                 we;
        logic [REG_IDX_W-1:0] rd;
    } ex_ls_t;

    // retire port, also the writeback bus
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 we;
        logic [XLEN-1:0]      data;
    } retire_t;

endpackage

`default_nettype wire

// ==== list.f ====
hw/core_pkg.sv
hw/pipe_pkg.sv
hw/fetch_queue.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/ls_stage.sv
hw/core_top.sv
dv/core_props.sv
dv/core_tb.sv
